// ==== source/map156_config.svh ====
`ifndef MAP156_CONFIG_SVH
`define MAP156_CONFIG_SVH

// Mapper number reported through the save-state port
`define MAP156_IDX 8'd156

// Cartridge bus widths
`define MAP156_CPU_AW 15
`define MAP156_PPU_AW 14
`define MAP156_PRG_AW 19
`define MAP156_CHR_AW 19
`define MAP156_SRM_AW 13

// Match values for {!ce, A14..A4} of a CPU register write
`define MAP156_CHR_BASE 12'hC00
`define MAP156_CTL_BASE 12'hC01

// Flat save-state register numbers
`define MAP156_SS_PRG 8'd16
`define MAP156_SS_MIR 8'd17
`define MAP156_SS_IDX 8'd127

`endif

// ==== source/map156_pkg.sv ====
`include "map156_config.svh"

package map156_pkg;

	typedef struct packed {
		logic [`MAP156_CPU_AW-1:0] addr;
		logic [7:0] data;
		logic rw;       // High for a read cycle
		logic ce;       // Low when the CPU selects ROM space
	} cpu_bus_t;

	typedef struct packed {
		logic [`MAP156_PPU_AW-1:0] addr;
		logic oe;       // Active low
		logic we;       // Active low
	} ppu_bus_t;

	// One save-state address byte, read either as a register number or as group and index
	typedef union packed {
		logic [7:0] flat;
		struct packed {
			logic [4:0] grp;
			logic [2:0] idx;
		} chr;
	} ss_addr_u;

	typedef struct packed {
		logic act;
		logic we;
		ss_addr_u addr;
	} ss_bus_t;

	typedef enum logic [2:0] {
		REG_NONE,
		REG_CHR_LO,
		REG_CHR_HI,
		REG_PRG,
		REG_MIRROR
	} reg_kind_e;

	typedef struct packed {
		reg_kind_e kind;
		logic [2:0] bank;       // CHR slot for the two CHR kinds
		logic set_enable;       // New mirror_enable for a mirror write
		logic [7:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic [`MAP156_PRG_AW-1:0] prg_addr;
		logic [`MAP156_CHR_AW-1:0] chr_addr;
		logic [`MAP156_SRM_AW-1:0] srm_addr;
		logic ram_ce;
		logic ram_we;
		logic rom_ce;
		logic prg_oe;
		logic chr_ce;
		logic chr_we;
		logic chr_oe;
		logic ciram_a10;
		logic ciram_ce;
	} map_out_t;

	typedef struct packed {
		logic [7:0][8:0] chr;   // 1 KB bank number per PPU slot
		logic [4:0] prg;
		logic mirror;
		logic mirror_enable;
	} bank_state_t;

endpackage

// ==== source/map156_reg_decode.sv ====
`timescale 1ns/100ps
`include "map156_config.svh"

module map156_reg_decode (
	input  map156_pkg::cpu_bus_t cpu,
	input  map156_pkg::ss_bus_t  ss,
	output map156_pkg::reg_wr_t  wr
);
	import map156_pkg::*;

	logic [11:0] cpu_sel;
	logic cpu_wr;
	reg_wr_t cpu_cmd;
	reg_wr_t ss_cmd;

	assign cpu_sel = {~cpu.ce, cpu.addr[14:4]};     // Same match form as the board's ROM decode
	assign cpu_wr = ~cpu.rw;

	// CPU side, two blocks of sixteen registers at $C000 and $C010
	always_comb begin
		cpu_cmd = '0;
		cpu_cmd.data = cpu.data;
		cpu_cmd.bank = {cpu.addr[3], cpu.addr[1:0]};    // Offsets 8..15 address banks 4..7
		if (cpu_wr && cpu_sel == `MAP156_CHR_BASE) begin
			if (cpu.addr[2])
				cpu_cmd.kind = REG_CHR_HI;
			else
				cpu_cmd.kind = REG_CHR_LO;
		end else if (cpu_wr && cpu_sel == `MAP156_CTL_BASE) begin
			if (cpu.addr[3:0] == 4'd0) begin
				cpu_cmd.kind = REG_PRG;
			end else if (cpu.addr[3:0] == 4'd4) begin
				cpu_cmd.kind = REG_MIRROR;
				cpu_cmd.data = {7'd0, cpu.data[0]};
				cpu_cmd.set_enable = 1'b1;    // Any mirror write turns mirroring on
			end
		end
	end

	// Save-state side, data still arrives on the CPU data bus
	always_comb begin
		ss_cmd = '0;
		ss_cmd.data = cpu.data;
		ss_cmd.bank = ss.addr.chr.idx;
		if (ss.we) begin
			if (ss.addr.chr.grp == 5'd0) begin
				ss_cmd.kind = REG_CHR_LO;
			end else if (ss.addr.chr.grp == 5'd1) begin
				ss_cmd.kind = REG_CHR_HI;
			end else if (ss.addr.flat == `MAP156_SS_PRG) begin
				ss_cmd.kind = REG_PRG;
			end else if (ss.addr.flat == `MAP156_SS_MIR) begin
				ss_cmd.kind = REG_MIRROR;
				ss_cmd.data = {7'd0, cpu.data[1]};    // Packed as {mirror, mirror_enable}
				ss_cmd.set_enable = cpu.data[0];
			end
		end
	end

	// A save-state session owns the registers, CPU writes are dropped meanwhile
	assign wr = ss.act ? ss_cmd : cpu_cmd;

endmodule

// ==== source/map156_bank_regs.sv ====
`timescale 1ns/100ps
`include "map156_config.svh"

module map156_bank_regs (
	input  logic m2,
	input  logic map_rst,
	input  map156_pkg::reg_wr_t wr,
	input  map156_pkg::ss_addr_u ss_addr,
	output map156_pkg::bank_state_t state,
	output logic [7:0] ss_rdat
);
	import map156_pkg::*;

	logic [15:0] chr_bank [8];      // Full 16-bit words so save states round-trip
	logic [7:0] prg_bank;
	logic mirror;
	logic mirror_enable;

	// Bank contents survive reset like the original board
	always_ff @(posedge m2) begin
		case (wr.kind)
			REG_CHR_LO: chr_bank[wr.bank][7:0] <= wr.data;
			REG_CHR_HI: chr_bank[wr.bank][15:8] <= wr.data;
			REG_PRG: prg_bank <= wr.data;
			REG_MIRROR: mirror <= wr.data[0];
			default: ;
		endcase
	end

	always_ff @(posedge m2) begin
		if (map_rst)
			mirror_enable <= 1'b0;      // One-screen nametables until the game picks a mode
		else if (wr.kind == REG_MIRROR)
			mirror_enable <= wr.set_enable;
	end

	// Save-state readback uses the same layout as the writes
	always_comb begin
		if (ss_addr.chr.grp == 5'd0)
			ss_rdat = chr_bank[ss_addr.chr.idx][7:0];
		else if (ss_addr.chr.grp == 5'd1)
			ss_rdat = chr_bank[ss_addr.chr.idx][15:8];
		else if (ss_addr.flat == `MAP156_SS_PRG)
			ss_rdat = prg_bank;
		else if (ss_addr.flat == `MAP156_SS_MIR)
			ss_rdat = {6'd0, mirror, mirror_enable};
		else if (ss_addr.flat == `MAP156_SS_IDX)
			ss_rdat = `MAP156_IDX;
		else
			ss_rdat = 8'hFF;    // Unused save-state slots read as open
	end

	// Only the low bits of each bank reach the address map
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			state.chr[i] = chr_bank[i][8:0];     // 512 KB of CHR space
		end
		state.prg = prg_bank[4:0];
		state.mirror = mirror;
		state.mirror_enable = mirror_enable;
	end

endmodule

// ==== source/map156_addr_map.sv ====
`timescale 1ns/100ps
`include "map156_config.svh"

module map156_addr_map (
	input  map156_pkg::cpu_bus_t cpu,
	input  map156_pkg::ppu_bus_t ppu,
	input  map156_pkg::bank_state_t state,
	input  logic cfg_chr_ram,
	output map156_pkg::map_out_t map_out
);
	import map156_pkg::*;

	logic [5:0] prg_hi;
	logic [8:0] chr_hi;
	logic ram_sel;
	logic pattern_sel;
	logic nt_a10;

	// PRG windows, switchable at $8000 and the last 16 KB at $C000
	always_comb begin
		if (cpu.ce)
			prg_hi = 6'd0;      // Outside ROM space the upper lines rest low
		else if (!cpu.addr[14])
			prg_hi = {state.prg, cpu.addr[13]};
		else
			prg_hi = {5'h1F, cpu.addr[13]};
	end

	// Each 1 KB PPU slot takes its bank from A12..A10
	assign chr_hi = state.chr[ppu.addr[12:10]];

	// Work RAM sits at $6000 when ROM space is not selected
	assign ram_sel = (cpu.addr[14:13] == 2'b11) && cpu.ce;

	// PPU A13 low means pattern tables, high means nametables
	assign pattern_sel = ~ppu.addr[13];

	// Mirror 0 gives vertical arrangement, 1 gives horizontal
	always_comb begin
		if (!state.mirror_enable)
			nt_a10 = 1'b0;
		else if (!state.mirror)
			nt_a10 = ppu.addr[10];
		else
			nt_a10 = ppu.addr[11];
	end

	always_comb begin
		map_out.prg_addr = {prg_hi, cpu.addr[12:0]};
		map_out.chr_addr = {chr_hi, ppu.addr[9:0]};
		map_out.srm_addr = cpu.addr[`MAP156_SRM_AW-1:0];    // 8 KB of work RAM, no banking
		map_out.ram_ce = ram_sel;
		map_out.ram_we = ram_sel & ~cpu.rw;
		map_out.rom_ce = ~cpu.ce;
		map_out.prg_oe = cpu.rw;
		map_out.chr_ce = pattern_sel;
		map_out.chr_we = cfg_chr_ram & ~ppu.we & pattern_sel;   // CHR ROM boards never write
		map_out.chr_oe = ~ppu.oe;
		map_out.ciram_a10 = nt_a10;
		map_out.ciram_ce = pattern_sel;      // Console VRAM serves the nametable half
	end

endmodule

// ==== source/map156_top.sv ====
`timescale 1ns/100ps

module map156_top (
	input  logic m2,
	input  logic map_rst,
	input  map156_pkg::cpu_bus_t cpu,
	input  map156_pkg::ppu_bus_t ppu,
	input  map156_pkg::ss_bus_t ss,
	input  logic cfg_chr_ram,
	output map156_pkg::map_out_t map_out,
	output logic [7:0] ss_rdat
);
	import map156_pkg::*;

	reg_wr_t wr;          // One register update per m2 cycle
	bank_state_t state;

	map156_reg_decode u_reg_decode (
		.cpu (cpu),
		.ss  (ss),
		.wr  (wr)
	);

	map156_bank_regs u_bank_regs (
		.m2      (m2),
		.map_rst (map_rst),
		.wr      (wr),
		.ss_addr (ss.addr),
		.state   (state),
		.ss_rdat (ss_rdat)
	);

	map156_addr_map u_addr_map (
		.cpu         (cpu),
		.ppu         (ppu),
		.state       (state),
		.cfg_chr_ram (cfg_chr_ram),
		.map_out     (map_out)
	);

endmodule

// ==== test/map156_tb_vectors.svh ====
// Columns are name, operation, address, data, checked output and expected value
// PPU rows pack oe in data bit 0, we in bit 1 and cfg_chr_ram in bit 2
// Strobe rows expect {prg_oe, chr_oe, ram_ce, ram_we, rom_ce, chr_ce, chr_we, ciram_ce}
task automatic load_vectors();
	// Nametable select is held at 0 until the first mirror write
	add_row("nt_reset",     OP_PPU,    16'h2C00, 8'h02, CHK_CIRAM,  19'h0);
	add_row("mir_vert",     OP_CPU_WR, 16'hC014, 8'h00, CHK_NONE,   19'h0);
	add_row("nt_vert_a10",  OP_PPU,    16'h2400, 8'h02, CHK_CIRAM,  19'h1);
	add_row("nt_vert_a11",  OP_PPU,    16'h2800, 8'h02, CHK_CIRAM,  19'h0);
	add_row("mir_horz",     OP_CPU_WR, 16'hC014, 8'h01, CHK_NONE,   19'h0);
	add_row("nt_horz_a10",  OP_PPU,    16'h2400, 8'h02, CHK_CIRAM,  19'h0);
	add_row("nt_horz_a11",  OP_PPU,    16'h2800, 8'h02, CHK_CIRAM,  19'h1);
	add_row("chr0_lo",      OP_CPU_WR, 16'hC000, 8'h12, CHK_NONE,   19'h0);
	add_row("chr0_hi",      OP_CPU_WR, 16'hC004, 8'h01, CHK_NONE,   19'h0);
	add_row("chr1_lo",      OP_CPU_WR, 16'hC001, 8'h34, CHK_NONE,   19'h0);
	add_row("chr1_hi",      OP_CPU_WR, 16'hC005, 8'h00, CHK_NONE,   19'h0);
	add_row("chr2_lo",      OP_CPU_WR, 16'hC002, 8'h56, CHK_NONE,   19'h0);
	add_row("chr2_hi",      OP_CPU_WR, 16'hC006, 8'h01, CHK_NONE,   19'h0);
	add_row("chr3_lo",      OP_CPU_WR, 16'hC003, 8'h78, CHK_NONE,   19'h0);
	add_row("chr3_hi",      OP_CPU_WR, 16'hC007, 8'hFE, CHK_NONE,   19'h0);    // Only bit 0 is a bank bit
	add_row("chr4_lo",      OP_CPU_WR, 16'hC008, 8'h9A, CHK_NONE,   19'h0);
	add_row("chr4_hi",      OP_CPU_WR, 16'hC00C, 8'h01, CHK_NONE,   19'h0);
	add_row("chr5_lo",      OP_CPU_WR, 16'hC009, 8'hBC, CHK_NONE,   19'h0);
	add_row("chr5_hi",      OP_CPU_WR, 16'hC00D, 8'h00, CHK_NONE,   19'h0);
	add_row("chr6_lo",      OP_CPU_WR, 16'hC00A, 8'hDE, CHK_NONE,   19'h0);
	add_row("chr6_hi",      OP_CPU_WR, 16'hC00E, 8'h01, CHK_NONE,   19'h0);
	add_row("chr7_lo",      OP_CPU_WR, 16'hC00B, 8'hF0, CHK_NONE,   19'h0);
	add_row("chr7_hi",      OP_CPU_WR, 16'hC00F, 8'h03, CHK_NONE,   19'h0);
	add_row("chr_slot0",    OP_PPU,    16'h03FF, 8'h02, CHK_CHR,    19'h44BFF);
	add_row("chr_slot1",    OP_PPU,    16'h0401, 8'h02, CHK_CHR,    19'h0D001);
	add_row("chr_slot2",    OP_PPU,    16'h0955, 8'h02, CHK_CHR,    19'h55955);
	add_row("chr_slot3",    OP_PPU,    16'h0EAA, 8'h02, CHK_CHR,    19'h1E2AA);
	add_row("chr_slot4",    OP_PPU,    16'h1000, 8'h02, CHK_CHR,    19'h66800);
	add_row("chr_slot5",    OP_PPU,    16'h1523, 8'h02, CHK_CHR,    19'h2F123);
	add_row("chr_slot6",    OP_PPU,    16'h1BC0, 8'h02, CHK_CHR,    19'h77BC0);
	add_row("chr_slot7",    OP_PPU,    16'h1C5A, 8'h02, CHK_CHR,    19'h7C05A);
	// PRG bank 0x2B keeps 0x0B in the five bank bits
	add_row("prg_write",    OP_CPU_WR, 16'hC010, 8'h2B, CHK_NONE,   19'h0);
	add_row("prg_8000",     OP_CPU_RD, 16'h8000, 8'h00, CHK_PRG,    19'h2C000);
	add_row("prg_a123",     OP_CPU_RD, 16'hA123, 8'h00, CHK_PRG,    19'h2E123);
	add_row("prg_c456",     OP_CPU_RD, 16'hC456, 8'h00, CHK_PRG,    19'h7C456);
	add_row("prg_ffff",     OP_CPU_RD, 16'hFFFF, 8'h00, CHK_PRG,    19'h7FFFF);
	add_row("prg_ce_high",  OP_CPU_RD, 16'h6ABC, 8'h00, CHK_PRG,    19'h00ABC);
	// Save-state rows also present a CPU write to $C014 that must be ignored
	add_row("ss_chr5_lo",   OP_SS_WR,  16'h0005, 8'h44, CHK_NONE,   19'h0);
	add_row("ss_rd_chr5",   OP_SS_RD,  16'h0005, 8'h00, CHK_SS,     19'h44);
	add_row("ss_cpu_block", OP_SS_RD,  16'h0011, 8'h00, CHK_SS,     19'h03);
	add_row("ss_chr5_hi",   OP_SS_WR,  16'h000D, 8'h00, CHK_NONE,   19'h0);
	add_row("ss_chr_slot5", OP_PPU,    16'h1400, 8'h02, CHK_CHR,    19'h11000);
	add_row("ss_prg",       OP_SS_WR,  16'h0010, 8'h15, CHK_NONE,   19'h0);
	add_row("ss_rd_prg",    OP_SS_RD,  16'h0010, 8'h00, CHK_SS,     19'h15);
	add_row("ss_prg_probe", OP_CPU_RD, 16'h8000, 8'h00, CHK_PRG,    19'h54000);
	add_row("ss_mir_off",   OP_SS_WR,  16'h0011, 8'h02, CHK_NONE,   19'h0);
	add_row("ss_rd_mir",    OP_SS_RD,  16'h0011, 8'h00, CHK_SS,     19'h02);
	add_row("ss_nt_off",    OP_PPU,    16'h2C00, 8'h02, CHK_CIRAM,  19'h0);
	add_row("ss_mir_on",    OP_SS_WR,  16'h0011, 8'h01, CHK_NONE,   19'h0);
	add_row("ss_nt_on",     OP_PPU,    16'h2400, 8'h02, CHK_CIRAM,  19'h1);
	add_row("ss_rd_chr4h",  OP_SS_RD,  16'h000C, 8'h00, CHK_SS,     19'h01);
	add_row("ss_rd_chr3l",  OP_SS_RD,  16'h0003, 8'h00, CHK_SS,     19'h78);
	add_row("ss_rd_chr3h",  OP_SS_RD,  16'h000B, 8'h00, CHK_SS,     19'hFE);
	add_row("ss_rd_index",  OP_SS_RD,  16'h007F, 8'h00, CHK_SS,     19'h9C);
	add_row("ss_rd_unused", OP_SS_RD,  16'h0028, 8'h00, CHK_SS,     19'hFF);
	add_row("stb_ram_wr",   OP_CPU_WR, 16'h6000, 8'h00, CHK_STROBE, 19'h35);
	add_row("stb_ram_rd",   OP_CPU_RD, 16'h7FFF, 8'h00, CHK_STROBE, 19'hA5);
	add_row("stb_io_wr",    OP_CPU_WR, 16'h4000, 8'h00, CHK_STROBE, 19'h05);
	add_row("stb_rom_rd",   OP_CPU_RD, 16'hE000, 8'h00, CHK_STROBE, 19'h8D);
	add_row("stb_chr_ram",  OP_PPU,    16'h0123, 8'h05, CHK_STROBE, 19'h87);
	add_row("stb_chr_rom",  OP_PPU,    16'h0123, 8'h01, CHK_STROBE, 19'h85);
	add_row("stb_nt_wr",    OP_PPU,    16'h2123, 8'h05, CHK_STROBE, 19'h80);
	add_row("stb_chr_rd",   OP_PPU,    16'h0123, 8'h06, CHK_STROBE, 19'hC5);
	// Work RAM address is CPU A12..A0 of the 8 KB window
	add_row("srm_rd",       OP_CPU_RD, 16'h6ABC, 8'h00, CHK_SRM,    19'h00ABC);
	add_row("srm_wr",       OP_CPU_WR, 16'h7F01, 8'h00, CHK_SRM,    19'h01F01);
endtask

// ==== test/map156_tb.sv ====
`timescale 1ns/100ps

module map156_tb;
	import map156_pkg::*;

	typedef enum logic [2:0] {
		OP_CPU_WR,
		OP_CPU_RD,
		OP_PPU,
		OP_SS_WR,
		OP_SS_RD
	} op_e;

	typedef enum logic [2:0] {
		CHK_NONE,
		CHK_PRG,
		CHK_CHR,
		CHK_CIRAM,
		CHK_SS,
		CHK_STROBE,
		CHK_SRM
	} chk_e;

	typedef struct packed {
		logic [95:0] name;      // Up to twelve characters
		op_e op;
		logic [15:0] addr;
		logic [7:0] data;
		chk_e sel;
		logic [18:0] exp;
	} vec_t;

	logic m2;
	logic map_rst;
	cpu_bus_t cpu;
	ppu_bus_t ppu;
	ss_bus_t ss;
	logic cfg_chr_ram;
	map_out_t map_out;
	logic [7:0] ss_rdat;
	vec_t vectors [$];
	integer seed;

	map156_top u_map156_top (
		.m2          (m2),
		.map_rst     (map_rst),
		.cpu         (cpu),
		.ppu         (ppu),
		.ss          (ss),
		.cfg_chr_ram (cfg_chr_ram),
		.map_out     (map_out),
		.ss_rdat     (ss_rdat)
	);

	initial m2 = 1'b0;
	always #2 m2 = ~m2;     // 4 ns period

	function automatic vec_t make_row(input logic [95:0] name, input op_e op,
			input logic [15:0] addr, input logic [7:0] data, input chk_e sel,
			input logic [18:0] exp);
		vec_t row;
		row.name = name;
		row.op = op;
		row.addr = addr;
		row.data = data;
		row.sel = sel;
		row.exp = exp;
		return row;
	endfunction

	task automatic add_row(input logic [95:0] name, input op_e op, input logic [15:0] addr,
			input logic [7:0] data, input chk_e sel, input logic [18:0] exp);
		vectors.push_back(make_row(name, op, addr, data, sel, exp));
	endtask

	`include "map156_tb_vectors.svh"

	// CHR register offset within $C000..$C00F for one slot and byte half
	function automatic logic [3:0] chr_reg_offset(input logic [2:0] slot, input logic high);
		return {slot[2], high, slot[1:0]};
	endfunction

	task automatic check_value(input logic [95:0] name, input logic [18:0] expected,
			input logic [18:0] actual);
		if (actual !== expected) begin
			$display("Error: test %0s expected %h actual %h", name, expected, actual);
			$display("tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic set_idle();
		cpu.addr = '0;
		cpu.data = '0;
		cpu.rw = 1'b1;
		cpu.ce = 1'b1;      // Idle CPU sits outside ROM space
		ppu.addr = '0;
		ppu.oe = 1'b1;
		ppu.we = 1'b1;
		ss.act = 1'b0;
		ss.we = 1'b0;
		ss.addr.flat = '0;
		cfg_chr_ram = 1'b0;
	endtask

	function automatic logic [18:0] observed(input chk_e sel);
		case (sel)
			CHK_PRG: return map_out.prg_addr;
			CHK_CHR: return map_out.chr_addr;
			CHK_CIRAM: return {18'd0, map_out.ciram_a10};
			CHK_SS: return {11'd0, ss_rdat};
			CHK_STROBE: return {11'd0, map_out.prg_oe, map_out.chr_oe, map_out.ram_ce,
				map_out.ram_we, map_out.rom_ce, map_out.chr_ce, map_out.chr_we,
				map_out.ciram_ce};
			CHK_SRM: return {6'd0, map_out.srm_addr};
			default: return '0;
		endcase
	endfunction

	// Drive one row for a full m2 cycle and sample just before releasing it
	task automatic apply_row(input vec_t row);
		@(negedge m2);
		set_idle();
		case (row.op)
			OP_CPU_WR, OP_CPU_RD: begin
				cpu.addr = row.addr[14:0];
				cpu.ce = ~row.addr[15];     // $8000..$FFFF is ROM space
				cpu.rw = (row.op == OP_CPU_RD);
				cpu.data = row.data;
			end
			OP_PPU: begin
				ppu.addr = row.addr[13:0];
				ppu.oe = row.data[0];
				ppu.we = row.data[1];
				cfg_chr_ram = row.data[2];
			end
			OP_SS_WR: begin
				ss.act = 1'b1;
				ss.we = 1'b1;
				ss.addr.flat = row.addr[7:0];
				cpu.addr = 15'h4014;        // Competing CPU mirror write
				cpu.ce = 1'b0;
				cpu.rw = 1'b0;
				cpu.data = row.data;
			end
			OP_SS_RD: begin
				ss.act = 1'b1;
				ss.addr.flat = row.addr[7:0];
			end
			default: ;
		endcase
		@(negedge m2);
		if (row.sel != CHK_NONE)
			check_value(row.name, row.exp, observed(row.sel));
		set_idle();
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		ppu.addr = 14'h2C00;        // Nametable address with A10 and A11 both set
		while (map_out.ciram_a10 !== 1'b0 && cycles < 32) begin
			@(negedge m2);
			cycles++;
		end
		if (map_out.ciram_a10 !== 1'b0) begin
			$display("Timeout: ciram_a10 did not settle to 0 after reset");
			$display("tests failed");
			$fatal(1, "Reset release timed out");
		end
	endtask

	task automatic random_chr_phase();
		logic [31:0] rnd;
		logic [8:0] bank;
		logic [2:0] slot;
		logic [9:0] offset;
		logic [6:0] spare;
		for (int n = 0; n < 40; n++) begin
			rnd = $random(seed);
			bank = rnd[8:0];
			slot = rnd[11:9];
			spare = rnd[18:12];     // Upper high-byte bits carry no bank bits
			rnd = $random(seed);
			offset = rnd[9:0];
			apply_row(make_row("rand_lo", OP_CPU_WR, {12'hC00, chr_reg_offset(slot, 1'b0)},
				bank[7:0], CHK_NONE, 19'h0));
			apply_row(make_row("rand_hi", OP_CPU_WR, {12'hC00, chr_reg_offset(slot, 1'b1)},
				{spare, bank[8]}, CHK_NONE, 19'h0));
			apply_row(make_row("rand_chr", OP_PPU, {3'd0, slot, offset}, 8'h02, CHK_CHR,
				{bank, offset}));
		end
	endtask

	initial begin
		seed = 95;
		set_idle();
		map_rst = 1'b1;
		for (int i = 0; i < 16; i++)
			@(posedge m2);
		@(negedge m2);
		map_rst = 1'b0;
		wait_reset_release();
		load_vectors();
		foreach (vectors[i])
			apply_row(vectors[i]);
		random_chr_phase();
		$display("all tests passed");
		$finish;
	end

endmodule

// ==== map156.f ====
+incdir+source
+incdir+test
source/map156_pkg.sv
source/map156_reg_decode.sv
source/map156_bank_regs.sv
source/map156_addr_map.sv
source/map156_top.sv
test/map156_tb.sv

// ==== Bender.yml ====
package:
  name: map156

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/map156_pkg.sv
      - source/map156_reg_decode.sv
      - source/map156_bank_regs.sv
      - source/map156_addr_map.sv
      - source/map156_top.sv

  - target: test
    include_dirs:
      - source
      - test
    files:
      - test/map156_tb.sv
